//--- Bender.yml
package:
  name: sample_player

sources:
  - include_dirs:
      - logic
    files:
      - logic/player_pkg.sv
      - logic/button_events.sv
      - logic/speed_control.sv
      - logic/sample_pacer.sv
      - logic/flash_sample_reader.sv
      - logic/hex_display.sv
      - logic/sample_player_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/flash_model.sv
      - test/tb_sample_player.sv

//--- build.f
+incdir+logic
logic/player_pkg.sv
logic/button_events.sv
logic/speed_control.sv
logic/sample_pacer.sv
logic/flash_sample_reader.sv
logic/hex_display.sv
logic/sample_player_top.sv
test/flash_model.sv
test/tb_sample_player.sv

//--- logic/button_events.sv
`timescale 1ns/1ps
`include "player_config.svh"

module button_events (
  input  logic       clk,
  input  logic       reset,
  input  logic [2:0] key_n,
  output logic       up_event,
  output logic       down_event,
  output logic       restore_hold
);

  localparam int REPEAT_WIDTH = $clog2(`PLAYER_REPEAT_CYCLES);

  logic [2:0]              key_meta;
  logic [2:0]              key_sync;
  logic [REPEAT_WIDTH-1:0] repeat_count;
  logic                    repeat_wrap;

  // Two-flop synchronizer, keys become active high here
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      key_meta <= '0;
      key_sync <= '0;
    end
    else
    begin
      key_meta <= ~key_n;
      key_sync <= key_meta;
    end
  end

  // Free-running repeat interval
  assign repeat_wrap = (repeat_count == REPEAT_WIDTH'(`PLAYER_REPEAT_CYCLES - 1));

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      repeat_count <= '0;
      up_event     <= 1'b0;
      down_event   <= 1'b0;
    end
    else
    begin
      repeat_count <= repeat_wrap ? '0 : repeat_count + 1'b1;
      up_event     <= repeat_wrap & key_sync[0];
      down_event   <= repeat_wrap & key_sync[1];
    end
  end

  // Restore acts as a level
  assign restore_hold = key_sync[2];

  // Events are single-cycle pulses, never back to back
  assert property (@(posedge clk) disable iff (reset) up_event |=> !up_event)
    else $error("up_event held longer than one cycle");
  assert property (@(posedge clk) disable iff (reset) down_event |=> !down_event)
    else $error("down_event held longer than one cycle");

endmodule

//--- logic/flash_sample_reader.sv
`timescale 1ns/1ps
`include "player_config.svh"

module flash_sample_reader (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          sample_tick,
  input  logic                          flash_waitrequest,
  input  logic [31:0]                   flash_readdata,
  input  logic                          flash_readdatavalid,
  output logic                          flash_read,
  output logic [`PLAYER_ADDR_WIDTH-1:0] flash_address,
  output player_pkg::sample_t           sample,
  output logic                          sample_strobe
);
  import player_pkg::*;

  reader_state_t state;
  flash_word_t   word;

  // Captured flash word
  always_ff @(posedge clk)
  begin
    if (state == reader_wait_data && flash_readdatavalid)
    begin
      word.raw <= flash_readdata;
    end
  end

  // ======================================================================
  // Read and playback FSM
  // ======================================================================

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state         <= reader_issue;
      flash_read    <= 1'b0;
      flash_address <= '0;
      sample        <= '0;
      sample_strobe <= 1'b0;
    end
    else
    begin
      sample_strobe <= 1'b0;
      case (state)
        reader_issue:
        begin
          if (!flash_read)
          begin
            // First read after reset
            flash_read <= 1'b1;
          end
          else if (!flash_waitrequest)
          begin
            // Accepted, address moves on while the data is in flight
            flash_read    <= 1'b0;
            flash_address <= flash_address + 1'b1;
            state         <= reader_wait_data;
          end
        end
        reader_wait_data:
        begin
          if (flash_readdatavalid)
            state <= reader_play_low;
        end
        reader_play_low:
        begin
          if (sample_tick)
          begin
            sample        <= word.halves.low;
            sample_strobe <= 1'b1;
            state         <= reader_play_high;
          end
        end
        reader_play_high:
        begin
          if (sample_tick)
          begin
            sample        <= word.halves.high;
            sample_strobe <= 1'b1;
            flash_read    <= 1'b1;
            state         <= reader_issue;
          end
        end
        default: state <= reader_issue;
      endcase
    end
  end

  // A stalled read keeps its address until the flash takes it
  assert property (@(posedge clk) disable iff (reset)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address))
    else $error("read or address changed under waitrequest");

  assert property (@(posedge clk) disable iff (reset)
    flash_readdatavalid |-> state == reader_wait_data)
    else $error("readdatavalid with no read outstanding");

endmodule

//--- logic/hex_display.sv
`timescale 1ns/1ps
`include "player_config.svh"

module hex_display (
  input  logic                clk,
  input  logic                reset,
  input  player_pkg::period_t period,
  output logic [6:0]          hex0,
  output logic [6:0]          hex1,
  output logic [6:0]          hex2,
  output logic [6:0]          hex3,
  output logic [6:0]          hex4,
  output logic [6:0]          hex5
);

  localparam int SHOWN_WIDTH   = `PLAYER_DIGITS * 4;
  localparam int REFRESH_WIDTH = $clog2(`PLAYER_REFRESH_CYCLES);

  logic [REFRESH_WIDTH-1:0] refresh_count;
  logic [SHOWN_WIDTH-1:0]   shown;
  logic [6:0]               glyph [`PLAYER_DIGITS];

  // Active-low segments, bit 0 is a and bit 6 is g
  function automatic logic [6:0] hex_glyph(input logic [3:0] nibble);
    case (nibble)
      4'h0: hex_glyph = 7'h40;
      4'h1: hex_glyph = 7'h79;
      4'h2: hex_glyph = 7'h24;
      4'h3: hex_glyph = 7'h30;
      4'h4: hex_glyph = 7'h19;
      4'h5: hex_glyph = 7'h12;
      4'h6: hex_glyph = 7'h02;
      4'h7: hex_glyph = 7'h78;
      4'h8: hex_glyph = 7'h00;
      4'h9: hex_glyph = 7'h10;
      4'ha: hex_glyph = 7'h08;
      4'hb: hex_glyph = 7'h03;
      4'hc: hex_glyph = 7'h46;
      4'hd: hex_glyph = 7'h21;
      4'he: hex_glyph = 7'h06;
      default: hex_glyph = 7'h0e;
    endcase
  endfunction

  // Display only follows the period at the refresh rate
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      refresh_count <= '0;
      shown         <= SHOWN_WIDTH'(`PLAYER_DEFAULT_PERIOD);
    end
    else if (refresh_count == REFRESH_WIDTH'(`PLAYER_REFRESH_CYCLES - 1))
    begin
      refresh_count <= '0;
      shown         <= {{(SHOWN_WIDTH - `PLAYER_PERIOD_WIDTH){1'b0}}, period};
    end
    else
    begin
      refresh_count <= refresh_count + 1'b1;
    end
  end

  for (genvar d = 0; d < `PLAYER_DIGITS; d++)
  begin : g_digit
    assign glyph[d] = hex_glyph(shown[d*4 +: 4]);
  end

  assign hex0 = glyph[0];
  assign hex1 = glyph[1];
  assign hex2 = glyph[2];
  assign hex3 = glyph[3];
  assign hex4 = glyph[4];
  assign hex5 = glyph[5];

endmodule

//--- logic/player_config.svh
`ifndef PLAYER_CONFIG_SVH
`define PLAYER_CONFIG_SVH

// ======================================================================
// Flash and sample widths
// ======================================================================

// Word address into the flash
`define PLAYER_ADDR_WIDTH 23

// Sample period counter width
`define PLAYER_PERIOD_WIDTH 16

// ======================================================================
// Speed control, in clk cycles per sample
// ======================================================================

`define PLAYER_DEFAULT_PERIOD 40
`define PLAYER_PERIOD_STEP 8
`define PLAYER_MIN_PERIOD 16
`define PLAYER_MAX_PERIOD 96

// ======================================================================
// Slow event timing, scaled down for simulation
// ======================================================================

// Held key may step the period once per interval
`define PLAYER_REPEAT_CYCLES 200
`define PLAYER_REFRESH_CYCLES 50
`define PLAYER_DIGITS 6

`endif

//--- logic/player_pkg.sv
`include "player_config.svh"

package player_pkg;

  // One signed audio sample
  typedef logic signed [15:0] sample_t;

  // Sample period in clk cycles
  typedef logic [`PLAYER_PERIOD_WIDTH-1:0] period_t;

  // Flash word, seen whole or as two samples (low half plays first)
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      sample_t high;
      sample_t low;
    } halves;
  } flash_word_t;

  // Reader FSM
  typedef enum logic [1:0] {
    reader_issue,
    reader_wait_data,
    reader_play_low,
    reader_play_high
  } reader_state_t;

endpackage

//--- logic/sample_pacer.sv
`timescale 1ns/1ps
`include "player_config.svh"

module sample_pacer (
  input  logic                clk,
  input  logic                reset,
  input  player_pkg::period_t period,
  output logic                sample_tick
);
  import player_pkg::*;

  period_t count;

  // Down counter as a clock enable
  // reload from period at zero, so a new period waits for the wrap
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      count       <= period_t'(`PLAYER_DEFAULT_PERIOD - 1);
      sample_tick <= 1'b0;
    end
    else
    begin
      if (count == '0)
      begin
        count       <= period - 1'b1;
        sample_tick <= 1'b1;
      end
      else
      begin
        count       <= count - 1'b1;
        sample_tick <= 1'b0;
      end
    end
  end

  // Ticks are spaced at least by the minimum period
  assert property (@(posedge clk) disable iff (reset)
    sample_tick |=> !sample_tick [*(`PLAYER_MIN_PERIOD - 1)])
    else $error("sample ticks closer than the minimum period");

endmodule

//--- logic/sample_player_top.sv
`timescale 1ns/1ps
`include "player_config.svh"

module sample_player_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [2:0]                    key_n,
  input  logic                          flash_waitrequest,
  input  logic [31:0]                   flash_readdata,
  input  logic                          flash_readdatavalid,
  output logic                          flash_read,
  output logic [`PLAYER_ADDR_WIDTH-1:0] flash_address,
  output player_pkg::sample_t           sample,
  output logic                          sample_strobe,
  output logic [6:0]                    hex0,
  output logic [6:0]                    hex1,
  output logic [6:0]                    hex2,
  output logic [6:0]                    hex3,
  output logic [6:0]                    hex4,
  output logic [6:0]                    hex5
);
  import player_pkg::*;

  logic    up_event;
  logic    down_event;
  logic    restore_hold;
  logic    sample_tick;
  period_t period;

  // ======================================================================
  // Speed control path
  // ======================================================================

  button_events button_events_inst (
    .clk(clk), .reset(reset), .key_n(key_n),
    .up_event(up_event), .down_event(down_event), .restore_hold(restore_hold)
  );

  speed_control speed_control_inst (
    .clk(clk), .reset(reset),
    .up_event(up_event), .down_event(down_event), .restore_hold(restore_hold),
    .period(period)
  );

  hex_display hex_display_inst (
    .clk(clk), .reset(reset), .period(period),
    .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5)
  );

  // ======================================================================
  // Sound path
  // ======================================================================

  sample_pacer sample_pacer_inst (
    .clk(clk), .reset(reset), .period(period), .sample_tick(sample_tick)
  );

  flash_sample_reader flash_sample_reader_inst (
    .clk(clk), .reset(reset), .sample_tick(sample_tick),
    .flash_waitrequest(flash_waitrequest), .flash_readdata(flash_readdata),
    .flash_readdatavalid(flash_readdatavalid), .flash_read(flash_read),
    .flash_address(flash_address), .sample(sample), .sample_strobe(sample_strobe)
  );

endmodule

//--- logic/speed_control.sv
`timescale 1ns/1ps
`include "player_config.svh"

module speed_control (
  input  logic                clk,
  input  logic                reset,
  input  logic                up_event,
  input  logic                down_event,
  input  logic                restore_hold,
  output player_pkg::period_t period
);
  import player_pkg::*;

  localparam period_t DEFAULT_PERIOD = period_t'(`PLAYER_DEFAULT_PERIOD);
  localparam period_t STEP           = period_t'(`PLAYER_PERIOD_STEP);
  localparam period_t MIN_PERIOD     = period_t'(`PLAYER_MIN_PERIOD);
  localparam period_t MAX_PERIOD     = period_t'(`PLAYER_MAX_PERIOD);

  // ======================================================================
  // Period register
  // ======================================================================

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      period <= DEFAULT_PERIOD;
    end
    else if (restore_hold)
    begin
      period <= DEFAULT_PERIOD;
    end
    else if (up_event && !down_event)
    begin
      // Faster playback means a shorter period
      if (period < MIN_PERIOD + STEP)
        period <= MIN_PERIOD;
      else
        period <= period - STEP;
    end
    else if (down_event && !up_event)
    begin
      if (period > MAX_PERIOD - STEP)
        period <= MAX_PERIOD;
      else
        period <= period + STEP;
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    period >= MIN_PERIOD && period <= MAX_PERIOD)
    else $error("period %0d outside limits", period);

endmodule

//--- test/flash_model.sv
`timescale 1ns/1ps
`include "player_config.svh"

module flash_model (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          flash_read,
  input  logic [`PLAYER_ADDR_WIDTH-1:0] flash_address,
  output logic                          flash_waitrequest,
  output logic [31:0]                   flash_readdata,
  output logic                          flash_readdatavalid
);

  logic [31:0]                   wait_state;
  logic [`PLAYER_ADDR_WIDTH-1:0] pending_address;
  logic                          reset_sampled;
  int                            delay;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  initial
  begin
    flash_waitrequest   = 1'b0;
    flash_readdata      = '0;
    flash_readdatavalid = 1'b0;
    reset_sampled       = 1'b1;
  end

  // Reset as it stood at the last rising edge
  always @(posedge clk)
    reset_sampled <= reset;

  // Outputs change on the falling edge
  always @(negedge clk)
  begin
    if (reset_sampled)
    begin
      wait_state          = 32'h8b4;
      delay               = 0;
      pending_address     = '0;
      flash_waitrequest   <= 1'b0;
      flash_readdatavalid <= 1'b0;
    end
    else
    begin
      wait_state = xorshift32(wait_state);
      // Stall about one cycle in four
      flash_waitrequest   <= (wait_state[1:0] == 2'b11);
      flash_readdatavalid <= 1'b0;
      if (delay > 0)
      begin
        // Read data goes out 3 cycles after the accept
        delay = delay - 1;
        if (delay == 0)
        begin
          flash_readdatavalid <= 1'b1;
          flash_readdata      <= xorshift32(32'(pending_address) ^ 32'h8b4);
        end
      end
      if (flash_read && wait_state[1:0] != 2'b11 && delay == 0)
      begin
        pending_address = flash_address;
        delay           = 3;
      end
    end
  end

endmodule

//--- test/tb_sample_player.sv
`timescale 1ns/1ps
`include "player_config.svh"

module tb_sample_player;
  import player_pkg::*;

  localparam int ROWS   = 7;
  localparam int SETTLE = 2 * `PLAYER_REPEAT_CYCLES;
  localparam int DEF    = `PLAYER_DEFAULT_PERIOD;
  localparam int STEP   = `PLAYER_PERIOD_STEP;
  localparam int MIN    = `PLAYER_MIN_PERIOD;
  localparam int MAX    = `PLAYER_MAX_PERIOD;

  logic                          clk;
  logic                          reset;
  logic [2:0]                    key_n;
  logic                          flash_waitrequest;
  logic [31:0]                   flash_readdata;
  logic                          flash_readdatavalid;
  logic                          flash_read;
  logic [`PLAYER_ADDR_WIDTH-1:0] flash_address;
  sample_t                       sample;
  logic                          sample_strobe;
  logic [6:0]                    hex0;
  logic [6:0]                    hex1;
  logic [6:0]                    hex2;
  logic [6:0]                    hex3;
  logic [6:0]                    hex4;
  logic [6:0]                    hex5;

  int    cycle;
  int    strobe_count;
  int    last_strobe_cycle;
  int    words_delivered;
  int    monitor_errors;
  int    check_errors;
  int    errors_at_start;
  int    tests_run;
  int    tests_failed;
  logic  prev_read;
  logic  [`PLAYER_ADDR_WIDTH-1:0] prev_address;
  string current_test;

  // ======================================================================
  // Stimulus table with key pins, extra hold cycles, period and spacing check
  // ======================================================================

  string row_name [ROWS] = '{"up_one_step", "up_two_steps", "up_to_min",
    "up_held_at_min", "down_to_max", "down_held_at_max", "restore"};
  logic [2:0] row_key_n [ROWS] = '{3'b110, 3'b110, 3'b110, 3'b110, 3'b101, 3'b101, 3'b011};
  int row_hold [ROWS] = '{0, 0, 0, SETTLE, 0, SETTLE, 0};
  int row_period [ROWS] = '{DEF - STEP, DEF - 2 * STEP, MIN, MIN, MAX, MAX, DEF};
  bit row_spacing [ROWS] = '{0, 0, 0, 1, 0, 1, 1};

  // Lit segments per hex glyph with segment a in bit 0
  logic [6:0] lit_segments [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
    7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

  sample_player_top sample_player_top_inst (
    .clk(clk), .reset(reset), .key_n(key_n), .flash_waitrequest(flash_waitrequest),
    .flash_readdata(flash_readdata), .flash_readdatavalid(flash_readdatavalid),
    .flash_read(flash_read), .flash_address(flash_address), .sample(sample),
    .sample_strobe(sample_strobe), .hex0(hex0), .hex1(hex1), .hex2(hex2),
    .hex3(hex3), .hex4(hex4), .hex5(hex5)
  );

  flash_model flash_model_inst (
    .clk(clk), .reset(reset), .flash_read(flash_read), .flash_address(flash_address),
    .flash_waitrequest(flash_waitrequest), .flash_readdata(flash_readdata),
    .flash_readdatavalid(flash_readdatavalid)
  );

  always #2 clk = ~clk;

  always @(posedge clk)
    cycle <= cycle + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Period read back from the digits or -1 for an unknown glyph
  function automatic int read_display();
    logic [6:0] segs [6];
    int         value;
    int         digit;
    segs = '{hex0, hex1, hex2, hex3, hex4, hex5};
    value = 0;
    for (int d = 5; d >= 0; d--)
    begin
      digit = -1;
      for (int v = 0; v < 16; v++)
        if (segs[d] == ~lit_segments[v])
          digit = v;
      if (digit < 0)
        return -1;
      value = value * 16 + digit;
    end
    return value;
  endfunction

  // ======================================================================
  // Monitor for sample order and the read handshake
  // ======================================================================

  always @(negedge clk)
  begin
    logic [31:0] word;
    sample_t     expected;
    int          found;
    found = 0;
    if (!reset)
    begin
      prev_read    <= flash_read;
      prev_address <= flash_address;
      if (flash_readdatavalid)
        words_delivered <= words_delivered + 1;
      assert (!(prev_read && flash_waitrequest) || (flash_read && flash_address == prev_address))
      else
      begin
        $display("%s: read or address changed while waitrequest held it", current_test);
        found++;
      end
      if (sample_strobe)
      begin
        word = xorshift32((strobe_count / 2) ^ 32'h8b4);
        expected = strobe_count[0] ? word[31:16] : word[15:0];
        assert (words_delivered > strobe_count / 2)
        else
        begin
          $display("%s: strobe %0d came before its flash word", current_test, strobe_count);
          found++;
        end
        assert (sample === expected)
        else
        begin
          $display("error %s: strobe %0d expected %h, actual %h",
                   current_test, strobe_count, expected, sample);
          found++;
        end
        strobe_count      <= strobe_count + 1;
        last_strobe_cycle <= cycle;
      end
      monitor_errors <= monitor_errors + found;
    end
  end

  task automatic start_test(input string name);
    current_test    = name;
    errors_at_start = monitor_errors + check_errors;
  endtask

  task automatic finish_test();
    int found;
    found = monitor_errors + check_errors - errors_at_start;
    tests_run++;
    if (found == 0)
      $display("test %s: passed", current_test);
    else
    begin
      $display("test %s: failed with %0d errors", current_test, found);
      tests_failed++;
    end
  endtask

  task automatic wait_strobes(input int target, input int limit);
    int waited;
    waited = 0;
    while (strobe_count < target && waited < limit)
    begin
      @(negedge clk);
      waited++;
    end
    assert (strobe_count >= target)
    else
    begin
      $display("%s: timed out waiting for sample strobe %0d", current_test, target);
      check_errors++;
    end
  endtask

  // Skip two strobes so a new period has passed a pacer wrap
  task automatic check_spacing(input int period);
    int previous;
    int gap;
    wait_strobes(strobe_count + 2, 4 * MAX);
    for (int i = 0; i < 4; i++)
    begin
      previous = last_strobe_cycle;
      wait_strobes(strobe_count + 1, 3 * MAX);
      gap = last_strobe_cycle - previous;
      assert (gap == period)
      else
      begin
        $display("error %s: strobe spacing expected %0d, actual %0d", current_test, period, gap);
        check_errors++;
      end
    end
  endtask

  task automatic run_row(input int r);
    int waited;
    int shown;
    start_test(row_name[r]);
    @(negedge clk);
    key_n = row_key_n[r];
    repeat (row_hold[r]) @(negedge clk);
    waited = 0;
    shown  = read_display();
    while (shown != row_period[r] && waited < 12 * `PLAYER_REPEAT_CYCLES)
    begin
      @(negedge clk);
      waited++;
      shown = read_display();
    end
    key_n = 3'b111;
    assert (shown == row_period[r])
    else
    begin
      $display("%s: timed out waiting for the display to settle", current_test);
      $display("error %s: period expected %0d, actual %0d", current_test, row_period[r], shown);
      check_errors++;
    end
    if (row_spacing[r])
      check_spacing(row_period[r]);
    finish_test();
  endtask

  initial
  begin
    int waited;
    clk = 1'b0;
    reset = 1'b1;
    key_n = 3'b111;
    cycle = 0;
    strobe_count = 0;
    last_strobe_cycle = 0;
    words_delivered = 0;
    monitor_errors = 0;
    check_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    prev_read = 1'b0;
    prev_address = '0;
    current_test = "reset_state";
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    start_test("reset_state");
    assert (read_display() == DEF)
    else
    begin
      $display("error %s: period expected %0d, actual %0d", current_test, DEF, read_display());
      check_errors++;
    end
    assert (sample == 0)
    else
    begin
      $display("error %s: sample expected %h, actual %h", current_test, 16'h0, sample);
      check_errors++;
    end
    assert (!sample_strobe)
    else
    begin
      $display("error %s: sample_strobe expected 0, actual %b", current_test, sample_strobe);
      check_errors++;
    end
    waited = 0;
    while (!flash_read && waited < 20)
    begin
      @(negedge clk);
      waited++;
    end
    assert (flash_read)
    else
    begin
      $display("%s: timed out waiting for the first flash read", current_test);
      check_errors++;
    end
    assert (flash_address == 0)
    else
    begin
      $display("error %s: first read address expected 0, actual %0d", current_test, flash_address);
      check_errors++;
    end
    finish_test();

    start_test("sample_order");
    wait_strobes(16, 16 * 3 * DEF);
    finish_test();

    start_test("default_spacing");
    check_spacing(DEF);
    finish_test();

    for (int r = 0; r < ROWS; r++)
      run_row(r);

    $display("tests run %0d, passed %0d, failed %0d, strobes %0d",
             tests_run, tests_run - tests_failed, tests_failed, strobe_count);
    if (tests_failed == 0 && monitor_errors + check_errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
